// File: Makefile
# Verilator build and run of the tag store testbench

SIM  := obj_dir/Vtag_store_tb
SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tag_store_tb \
		-f verilog.f -o Vtag_store_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: logic/tag_match.sv
// Tag compare and hit detection of the tag store; forms the response and the entry write
module tag_match import tag_store_pkg::*; (
  input  tag_req_t       req_q_i,
  input  tag_entry_arr_t rdata_i,
  input  way_vec_t       spm_lock_i,
  // Replacement choice
  input  way_vec_t       victim_i,
  input  way_idx_t       victim_idx_i,
  input  logic           none_i,
  // Valid flags towards the replacement
  output way_vec_t       valid_o,
  output tag_res_t       res_o,
  output ram_wr_t        wr_o,
  output logic           wr_needed_o,
  output logic           miss_o
);

  way_vec_t hit;
  way_idx_t hit_idx;
  // Flush target in one-hot form
  way_vec_t flush_vec;

  // --------------------
  // Compare
  // --------------------

  // Locked ways never hit
  always_comb begin : proc_hit
    hit_idx = '0;
    for (int unsigned w = 0; w < NumWays; w++) begin
      valid_o[w] = rdata_i[w].val;
      hit[w]     = rdata_i[w].val & ~spm_lock_i[w] & (rdata_i[w].tag == req_q_i.tag);
      if (hit[w]) begin
        hit_idx = way_idx_t'(w);
      end
    end
  end

  assign flush_vec = way_vec_t'(1) << req_q_i.flush_way;

  // --------------------
  // Response and write
  // --------------------

  always_comb begin : proc_res
    res_o       = '0;
    wr_o        = '0;
    wr_o.index  = req_q_i.index;
    wr_needed_o = 1'b0;
    miss_o      = 1'b0;
    unique case (req_q_i.mode)
      mode_lookup: begin
        if (|hit) begin
          res_o.hit = 1'b1;
          res_o.way = hit;
          // Dirty bit set once, only on a clean line
          wr_o.en          = hit;
          wr_o.entry_val   = 1'b1;
          wr_o.entry_dirty = 1'b1;
          wr_needed_o      = req_q_i.dirty & ~rdata_i[hit_idx].dirty;
        end else if (!none_i) begin
          // Miss, replace the victim
          res_o.way   = victim_i;
          res_o.evict = rdata_i[victim_idx_i].val & rdata_i[victim_idx_i].dirty;
          if (res_o.evict) begin
            res_o.evict_tag = rdata_i[victim_idx_i].tag;
          end
          wr_o.en          = victim_i;
          wr_o.entry_val   = 1'b1;
          wr_o.entry_dirty = req_q_i.dirty;
          wr_needed_o      = 1'b1;
          miss_o           = 1'b1;
        end
        // All ways locked: everything stays zero
      end
      mode_flush: begin
        res_o.way   = flush_vec;
        res_o.evict = rdata_i[req_q_i.flush_way].val & rdata_i[req_q_i.flush_way].dirty;
        if (res_o.evict) begin
          res_o.evict_tag = rdata_i[req_q_i.flush_way].tag;
        end
        // Line invalidated and cleaned
        wr_o.en     = flush_vec;
        wr_needed_o = 1'b1;
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// File: logic/tag_ram.sv
// Tag memory of all ways with valid and dirty flags; one-cycle read, write on the issuing edge
module tag_ram import tag_store_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_i,
  // Read port
  input  logic           rd_en_i,
  input  index_t         rd_index_i,
  // Write port, tag from the held request
  input  ram_wr_t        wr_i,
  input  logic           wr_en_i,
  input  tag_t           wr_tag_i,
  // Entries of all ways, held until the next read
  output tag_entry_arr_t rdata_o
);

  // Tag storage per way and set
  tag_t tag_mem [NumWays][NumSets];

  // Flags per set, one bit per way
  way_vec_t [NumSets-1:0] val_q;
  way_vec_t [NumSets-1:0] dirty_q;

  tag_entry_arr_t rdata_q;

  // --------------------
  // Tag arrays
  // --------------------

  always_ff @(posedge clk_i) begin : proc_tag_wr
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (wr_en_i && wr_i.en[w]) begin
        tag_mem[w][wr_i.index] <= wr_tag_i;
      end
    end
  end

  // --------------------
  // Flags
  // --------------------

  // Cleared on reset, so every line starts invalid and clean
  always_ff @(posedge clk_i) begin : proc_flags
    if (rst_i) begin
      val_q   <= '0;
      dirty_q <= '0;
    end else begin
      for (int unsigned w = 0; w < NumWays; w++) begin
        if (wr_en_i && wr_i.en[w]) begin
          val_q[wr_i.index][w]   <= wr_i.entry_val;
          dirty_q[wr_i.index][w] <= wr_i.entry_dirty;
        end
      end
    end
  end

  // --------------------
  // Read
  // --------------------

  always_ff @(posedge clk_i) begin : proc_read
    if (rd_en_i) begin
      for (int unsigned w = 0; w < NumWays; w++) begin
        rdata_q[w].val   <= val_q[rd_index_i][w];
        rdata_q[w].dirty <= dirty_q[rd_index_i][w];
        rdata_q[w].tag   <= tag_mem[w][rd_index_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: logic/tag_store_ctrl.sv
// Request and response control of the tag store; sequences read, response hold and entry write
module tag_store_ctrl import tag_store_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Request side
  input  logic     req_valid_i,
  input  tag_req_t req_i,
  output logic     req_ready_o,
  // Response side
  output logic     res_valid_o,
  input  logic     res_ready_i,
  // Status from the compare logic
  input  logic     wr_needed_i,
  input  logic     miss_i,
  // Memory and counter control
  output logic     rd_en_o,
  output tag_req_t req_q_o,
  output logic     wr_en_o,
  output logic     advance_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Request taken this cycle
  logic accept;
  // Response taken this cycle
  logic res_take;

  // Held request, payload only
  tag_req_t req_q;

  // --------------------
  // Handshakes
  // --------------------

  // Only idle takes new work
  assign req_ready_o = (state_q == st_idle);
  assign accept      = req_ready_o & req_valid_i;

  // Read data is there one cycle after acceptance, so the response is valid in st_resp
  assign res_valid_o = (state_q == st_resp);
  assign res_take    = res_valid_o & res_ready_i;

  // Read starts straight on the accepting edge
  assign rd_en_o = accept;

  // --------------------
  // Write back
  // --------------------

  // Entry update one cycle after the response left
  assign wr_en_o = (state_q == st_write) & wr_needed_i;

  // Counter moves together with the write, so the victim seen by the write
  // is still the one that was reported
  assign advance_o = (state_q == st_write) & miss_i;

  // --------------------
  // State machine
  // --------------------

  always_comb begin : proc_next_state
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (accept) begin
          state_d = st_resp;
        end
      end
      // Waits here under back-pressure without a limit
      st_resp: begin
        if (res_take) begin
          state_d = st_write;
        end
      end
      st_write: begin
        state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin : proc_state
    if (rst_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request captured on acceptance, held until the next one
  always_ff @(posedge clk_i) begin : proc_req
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign req_q_o = req_q;

endmodule

// File: logic/tag_store_pkg.sv
// Shared widths, types and structs of the LLC tag store; imported by every RTL block and the testbench
package tag_store_pkg;

  // --------------------
  // Geometry
  // --------------------

  // Ways per set
  localparam int unsigned NumWays    = 4;
  // Set index width, 32 sets
  localparam int unsigned IndexWidth = 5;
  // Stored tag width
  localparam int unsigned TagWidth   = 12;
  // Number of sets, derived
  localparam int unsigned NumSets    = 2 ** IndexWidth;

  // One bit per way: one-hot selects, lock masks, flags
  typedef logic [NumWays-1:0]         way_vec_t;
  // Binary way number
  typedef logic [$clog2(NumWays)-1:0] way_idx_t;
  typedef logic [IndexWidth-1:0]      index_t;
  typedef logic [TagWidth-1:0]        tag_t;

  // --------------------
  // Enums
  // --------------------

  typedef enum logic {
    mode_lookup = 1'b0,
    mode_flush  = 1'b1
  } req_mode_e;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_resp  = 2'd1,
    st_write = 2'd2
  } ctrl_state_e;

  // --------------------
  // Structs
  // --------------------

  // Request into the tag store
  typedef struct packed {
    req_mode_e mode;
    index_t    index;
    // Compared and stored on lookup
    tag_t      tag;
    // Lookup marks the line dirty
    logic      dirty;
    // Target of a flush
    way_idx_t  flush_way;
  } tag_req_t;

  // Response out of the tag store
  typedef struct packed {
    logic     hit;
    // Valid dirty line must be written back
    logic     evict;
    // One-hot selected way
    way_vec_t way;
    tag_t     evict_tag;
  } tag_res_t;

  // One stored line of a way
  typedef struct packed {
    logic val;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Entries of all ways of one set
  typedef tag_entry_t [NumWays-1:0] tag_entry_arr_t;

  // Write command, tag comes from the held request
  typedef struct packed {
    way_vec_t en;
    index_t   index;
    logic     entry_val;
    logic     entry_dirty;
  } ram_wr_t;

endpackage

// File: logic/tag_store_top.sv
// Top level of the LLC tag store; connects control, replacement, tag memory and compare
module tag_store_top import tag_store_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Request side
  input  logic     req_valid_i,
  input  tag_req_t req_i,
  output logic     req_ready_o,
  // Response side
  output logic     res_valid_o,
  output tag_res_t res_o,
  input  logic     res_ready_i,
  // Scratchpad ways
  input  way_vec_t spm_lock_i
);

  // Control
  logic           rd_en;
  tag_req_t       req_q;
  logic           wr_en;
  logic           advance;

  // Memory
  tag_entry_arr_t rdata;

  // Compare
  way_vec_t       valid;
  ram_wr_t        wr;
  logic           wr_needed;
  logic           miss;

  // Replacement
  way_vec_t       victim;
  way_idx_t       victim_idx;
  logic           none;

  // --------------------
  // Control
  // --------------------

  tag_store_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .res_valid_o ( res_valid_o ),
    .res_ready_i ( res_ready_i ),
    .wr_needed_i ( wr_needed   ),
    .miss_i      ( miss        ),
    .rd_en_o     ( rd_en       ),
    .req_q_o     ( req_q       ),
    .wr_en_o     ( wr_en       ),
    .advance_o   ( advance     )
  );

  victim_select i_victim (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .advance_i    ( advance    ),
    .valid_i      ( valid      ),
    .spm_lock_i   ( spm_lock_i ),
    .victim_o     ( victim     ),
    .victim_idx_o ( victim_idx ),
    .none_o       ( none       )
  );

  // --------------------
  // Data path
  // --------------------

  // Read index comes straight from the incoming request
  tag_ram i_ram (
    .clk_i      ( clk_i       ),
    .rst_i      ( rst_i       ),
    .rd_en_i    ( rd_en       ),
    .rd_index_i ( req_i.index ),
    .wr_i       ( wr          ),
    .wr_en_i    ( wr_en       ),
    .wr_tag_i   ( req_q.tag   ),
    .rdata_o    ( rdata       )
  );

  tag_match i_match (
    .req_q_i      ( req_q      ),
    .rdata_i      ( rdata      ),
    .spm_lock_i   ( spm_lock_i ),
    .victim_i     ( victim     ),
    .victim_idx_i ( victim_idx ),
    .none_i       ( none       ),
    .valid_o      ( valid      ),
    .res_o        ( res_o      ),
    .wr_o         ( wr         ),
    .wr_needed_o  ( wr_needed  ),
    .miss_o       ( miss       )
  );

endmodule

// File: logic/victim_select.sv
// Round-robin replacement for the tag store; picks the way that a lookup miss fills
module victim_select import tag_store_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  // Miss handed off, move the pointer
  input  logic     advance_i,
  // Valid flags of the looked-up set
  input  way_vec_t valid_i,
  // Scratchpad ways, never replaced
  input  way_vec_t spm_lock_i,
  output way_vec_t victim_o,
  output way_idx_t victim_idx_o,
  // All ways locked
  output logic     none_o
);

  // Round-robin pointer
  way_idx_t rr_q;

  // Unlocked ways
  way_vec_t free;
  // Unlocked and empty ways, filled first
  way_vec_t empty;

  assign free   = ~spm_lock_i;
  assign empty  = free & ~valid_i;
  assign none_o = ~(|free);

  // --------------------
  // Victim choice
  // --------------------

  always_comb begin : proc_pick
    way_idx_t cand;
    logic     found;
    cand         = '0;
    found        = 1'b0;
    victim_idx_o = '0;
    if (|empty) begin
      // Lowest empty way
      for (int unsigned i = 0; i < NumWays; i++) begin
        if (!found && empty[i]) begin
          found        = 1'b1;
          victim_idx_o = way_idx_t'(i);
        end
      end
    end else begin
      // First free way at or after the pointer, wrapping
      for (int unsigned i = 0; i < NumWays; i++) begin
        cand = way_idx_t'(rr_q + way_idx_t'(i));
        if (!found && free[cand]) begin
          found        = 1'b1;
          victim_idx_o = cand;
        end
      end
    end
    // One-hot form, zero when nothing is free
    victim_o = '0;
    if (found) begin
      victim_o[victim_idx_o] = 1'b1;
    end
  end

  // --------------------
  // Pointer
  // --------------------

  // Only a replaced valid line moves the pointer
  always_ff @(posedge clk_i) begin : proc_rr
    if (rst_i) begin
      rr_q <= '0;
    end else if (advance_i && |(victim_o & valid_i)) begin
      rr_q <= way_idx_t'(victim_idx_o + way_idx_t'(1));
    end
  end

endmodule

// File: verification/tag_store_chk.sv
// Protocol assertions on the tag store ports; bound into the top level by the testbench
module tag_store_chk import tag_store_pkg::*; (
  input logic     clk_i,
  input logic     rst_i,
  // Top level outputs, observed only
  input logic     req_ready_i,
  input logic     res_valid_i,
  input tag_res_t res_i,
  input logic     res_ready_i
);

  // --------------------
  // Response contents
  // --------------------

  // Selected way is one-hot, or empty when every way is locked
  way_onehot_a : assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_i |-> $onehot0(res_i.way))
    else $error("Response way select is not one-hot or zero");

  // Response held in place under back-pressure
  res_hold_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_i && !res_ready_i) |=> (res_valid_i && $stable(res_i)))
    else $error("Response dropped or changed before it was taken");

  // --------------------
  // Handshake exclusion
  // --------------------

  // No new request while a response is pending
  ready_excl_a : assert property (@(posedge clk_i) disable iff (rst_i)
    !(req_ready_i && res_valid_i))
    else $error("Request ready and response valid are high together");

endmodule

// File: verification/tag_store_tb.sv
// Self-checking testbench of the tag store; LFSR driven requests compared with a reference model
module tag_store_tb import tag_store_pkg::*; ();

  // Number of requests in the run
  localparam int NumTxn    = 600;
  // Cycles any wait may take
  localparam int WaitLimit = 50;

  logic     clk_i;
  logic     rst_i;
  logic     req_valid_i;
  tag_req_t req_i;
  logic     req_ready_o;
  logic     res_valid_o;
  tag_res_t res_o;
  logic     res_ready_i;
  way_vec_t spm_lock_i;

  logic [15:0] lfsr_q;
  int          checks;
  int          errors;
  int          timeouts;
  logic        hung;

  // Reference tag array and round-robin pointer
  logic     m_val   [NumSets][NumWays];
  logic     m_dirty [NumSets][NumWays];
  tag_t     m_tag   [NumSets][NumWays];
  way_idx_t m_rr;

  tag_store_top i_dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .res_valid_o ( res_valid_o ),
    .res_o       ( res_o       ),
    .res_ready_i ( res_ready_i ),
    .spm_lock_i  ( spm_lock_i  )
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [15:0] draw(input int unsigned nbits);
    logic [15:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[14:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("** Error @ %0t: %s", $time, what);
    end
  endtask

  // Expected response, model updated as the DUT write will do
  task automatic predict(input tag_req_t req, input way_vec_t lock, output tag_res_t exp);
    way_vec_t hit_w;
    int       vic;
    int       wi;
    exp = '0;
    if (req.mode == mode_flush) begin
      exp.way = way_vec_t'(1) << req.flush_way;
      if (m_val[req.index][req.flush_way] && m_dirty[req.index][req.flush_way]) begin
        exp.evict     = 1'b1;
        exp.evict_tag = m_tag[req.index][req.flush_way];
      end
      m_val[req.index][req.flush_way]   = 1'b0;
      m_dirty[req.index][req.flush_way] = 1'b0;
      return;
    end
    hit_w = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (m_val[req.index][w] && !lock[w] && m_tag[req.index][w] == req.tag) begin
        hit_w[w] = 1'b1;
      end
    end
    if (hit_w != '0) begin
      exp.hit = 1'b1;
      exp.way = hit_w;
      for (int w = 0; w < NumWays; w++) begin
        if (hit_w[w] && req.dirty) begin
          m_dirty[req.index][w] = 1'b1;
        end
      end
    end else if (lock != '1) begin
      vic = -1;
      // Lowest empty unlocked way wins
      for (int w = NumWays - 1; w >= 0; w--) begin
        if (!lock[w] && !m_val[req.index][w]) begin
          vic = w;
        end
      end
      // Otherwise first unlocked way from the pointer, wrapping
      if (vic < 0) begin
        for (int k = NumWays - 1; k >= 0; k--) begin
          wi = (int'(m_rr) + k) % int'(NumWays);
          if (!lock[wi]) begin
            vic = wi;
          end
        end
        m_rr = way_idx_t'(vic + 1);
      end
      exp.way[vic] = 1'b1;
      if (m_val[req.index][vic] && m_dirty[req.index][vic]) begin
        exp.evict     = 1'b1;
        exp.evict_tag = m_tag[req.index][vic];
      end
      m_val[req.index][vic]   = 1'b1;
      m_dirty[req.index][vic] = req.dirty;
      m_tag[req.index][vic]   = req.tag;
    end
  endtask

  // --------------------
  // One request
  // --------------------

  task automatic run_txn();
    tag_req_t    req;
    way_vec_t    lock;
    tag_res_t    exp;
    logic [15:0] r;
    int          n;
    r             = draw(2);
    req.mode      = (r[1:0] == 2'd0) ? mode_flush : mode_lookup;
    // Four sets and eight tags, so hits and conflicts are frequent
    r             = draw(2);
    req.index     = {r[1:0], 3'b101};
    r             = draw(3);
    req.tag       = {9'h0a5, r[2:0]};
    r             = draw(1);
    req.dirty     = r[0];
    r             = draw(2);
    req.flush_way = r[1:0];
    // Mostly unlocked, sometimes one way, now and then all
    r = draw(3);
    if (r[2:0] == 3'd7) begin
      lock = '1;
    end else if (r[2:0] >= 3'd5) begin
      r    = draw(2);
      lock = way_vec_t'(1) << r[1:0];
    end else begin
      lock = '0;
    end
    // Tag held in a locked way would be stored twice on a miss
    if (req.mode == mode_lookup && lock != '1) begin
      for (int w = 0; w < NumWays; w++) begin
        if (lock[w] && m_val[req.index][w] && m_tag[req.index][w] == req.tag) begin
          lock[w] = 1'b0;
        end
      end
    end
    // Idle gap
    r = draw(2);
    repeat (r[1:0]) begin
      @(posedge clk_i);
      #5;
    end
    n = 0;
    while (!req_ready_o) begin
      if (n == WaitLimit) begin
        $display("Timeout: req_ready_o did not return high for a new request");
        timeouts++;
        hung = 1'b1;
        return;
      end
      @(posedge clk_i);
      #5;
      n++;
    end
    predict(req, lock, exp);
    req_valid_i = 1'b1;
    req_i       = req;
    spm_lock_i  = lock;
    @(posedge clk_i);
    #5;
    req_valid_i = 1'b0;
    check_value(res_valid_o === 1'b1, "res_valid_o not high one cycle after acceptance");
    // Back-pressure before the response is taken
    r = draw(2);
    repeat (r[1:0]) begin
      @(posedge clk_i);
      #5;
    end
    n = 0;
    while (!res_valid_o) begin
      if (n == WaitLimit) begin
        $display("Timeout: res_valid_o never came for an accepted request");
        timeouts++;
        hung = 1'b1;
        return;
      end
      @(posedge clk_i);
      #5;
      n++;
    end
    check_value(res_o === exp, $sformatf("res_o %h, expected %h (mode %0d set %0d tag %h)",
                res_o, exp, req.mode, req.index, req.tag));
    res_ready_i = 1'b1;
    @(posedge clk_i);
    #5;
    res_ready_i = 1'b0;
    // Entry write cycle, nothing offered on either side
    check_value(res_valid_o === 1'b0 && req_ready_o === 1'b0,
                "res_valid_o or req_ready_o high in the cycle after the response");
    @(posedge clk_i);
    #5;
    check_value(req_ready_o === 1'b1, "req_ready_o not high two cycles after the response");
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    lfsr_q      = 16'd61348;
    checks      = 0;
    errors      = 0;
    timeouts    = 0;
    hung        = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b0;
    spm_lock_i  = '0;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        m_val[s][w]   = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
    end
    m_rr = '0;
    repeat (3) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    // Idle with no response pending straight out of reset
    check_value(req_ready_o === 1'b1 && res_valid_o === 1'b0,
                "req_ready_o low or res_valid_o high after reset");
    for (int t = 0; t < NumTxn && !hung; t++) begin
      run_txn();
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

bind tag_store_top tag_store_chk i_chk (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .req_ready_i ( req_ready_o ),
  .res_valid_i ( res_valid_o ),
  .res_i       ( res_o       ),
  .res_ready_i ( res_ready_i )
);

// File: verilog.f
logic/tag_store_pkg.sv
logic/tag_store_ctrl.sv
logic/victim_select.sv
logic/tag_ram.sv
logic/tag_match.sv
logic/tag_store_top.sv
verification/tag_store_chk.sv
verification/tag_store_tb.sv
